/* hdl/axi_wr_pkg.sv */
//--------------------------------------------------------------------
// single-beat AXI writes only, no strobes, bursts or read channels
// the register bank decodes byte addresses 0 to 63, one word per register
//--------------------------------------------------------------------
package axi_wr_pkg;

  localparam int id_width   = 6;
  localparam int addr_width = 12;
  localparam int data_width = 32;
  localparam int user_width = 6;
  localparam int reg_count  = 16;

  // B response codes, only OKAY and SLVERR are ever returned
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // each double buffer reports an entry count of 0 to 2
  localparam int db_status_width = 2;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [user_width-1:0] user;
  } aw_beat_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic [user_width-1:0] user;
  } w_beat_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [1:0]            resp;
    logic [user_width-1:0] user;
  } b_beat_t;

endpackage

/* hdl/axi_double_buffer.sv */
//--------------------------------------------------------------------
// two-entry valid/ready buffer, registered on both in_ready and out_data
// a beat written into an empty buffer is visible one cycle later
//--------------------------------------------------------------------
`timescale 1ns/10ps

module axi_double_buffer #(
  parameter type payload_t = logic
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  input  payload_t                               in_data,
  output logic                                   out_valid,
  input  logic                                   out_ready,
  output payload_t                               out_data,
  output logic [axi_wr_pkg::db_status_width-1:0] status
);

  import axi_wr_pkg::*;

  logic [db_status_width-1:0] count;
  logic                       full;
  logic                       push;
  logic                       pop;
  payload_t                   head_q;
  payload_t                   skid_q;

  assign full      = (count == db_status_width'(2));
  assign in_ready  = !full;
  assign out_valid = (count != '0);
  assign out_data  = head_q;
  assign status    = count;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------
  // head_q always holds the oldest entry, skid_q catches the second one
  always_ff @(posedge clk) begin
    case (count)
      db_status_width'(0): begin
        if (push) begin
          head_q <= in_data;
        end
      end
      db_status_width'(1): begin
        if (push && pop) begin
          head_q <= in_data;
        end else if (push) begin
          skid_q <= in_data;
        end
      end
      default: begin
        // no push can arrive while full, so only the skid moves up
        if (pop) begin
          head_q <= skid_q;
        end
      end
    endcase
  end

  // ------------------------------------------------------------------
  // assertions
  // ------------------------------------------------------------------
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  a_status_max: assert property (@(posedge clk) disable iff (!rst_n)
    status <= db_status_width'(2));

  // a full buffer that is not drained keeps its count and both entries
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    full && !out_ready |=> full && $stable(head_q) && $stable(skid_q));

endmodule

/* hdl/axi_wr_slave.sv */
//--------------------------------------------------------------------
// buffers AW, W and B and offers AW and W to the core only as a pair
// the core may take the two halves in different cycles
//--------------------------------------------------------------------
`timescale 1ns/10ps

module axi_wr_slave (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               awvalid,
  output logic                               awready,
  input  logic [axi_wr_pkg::id_width-1:0]    awid,
  input  logic [axi_wr_pkg::addr_width-1:0]  awaddr,
  input  logic [axi_wr_pkg::user_width-1:0]  awuser,
  input  logic                               wvalid,
  output logic                               wready,
  input  logic [axi_wr_pkg::id_width-1:0]    wid,
  input  logic [axi_wr_pkg::data_width-1:0]  wdata,
  input  logic [axi_wr_pkg::user_width-1:0]  wuser,
  output logic                               bvalid,
  input  logic                               bready,
  output logic [axi_wr_pkg::id_width-1:0]    bid,
  output logic [1:0]                         bresp,
  output logic [axi_wr_pkg::user_width-1:0]  buser,
  output logic                               core_awvalid,
  input  logic                               core_awready,
  output logic [axi_wr_pkg::id_width-1:0]    core_awid,
  output logic [axi_wr_pkg::addr_width-1:0]  core_awaddr,
  output logic [axi_wr_pkg::user_width-1:0]  core_awuser,
  output logic                               core_wvalid,
  input  logic                               core_wready,
  output logic [axi_wr_pkg::id_width-1:0]    core_wid,
  output logic [axi_wr_pkg::data_width-1:0]  core_wdata,
  output logic [axi_wr_pkg::user_width-1:0]  core_wuser,
  input  logic                               core_bvalid,
  output logic                               core_bready,
  input  logic [axi_wr_pkg::id_width-1:0]    core_bid,
  input  logic [1:0]                         core_bresp,
  input  logic [axi_wr_pkg::user_width-1:0]  core_buser,
  output logic [3*axi_wr_pkg::db_status_width-1:0] db_status
);

  import axi_wr_pkg::*;

  aw_beat_t aw_in;
  aw_beat_t aw_head;
  w_beat_t  w_in;
  w_beat_t  w_head;
  b_beat_t  b_in;
  b_beat_t  b_head;

  logic aw_head_valid;
  logic w_head_valid;
  logic pair_pop;
  logic pair_ready;
  logic aw_hs;
  logic w_hs;
  logic aw_taken;
  logic w_taken;

  logic [db_status_width-1:0] aw_status;
  logic [db_status_width-1:0] w_status;
  logic [db_status_width-1:0] b_status;

  assign db_status = {b_status, w_status, aw_status};

  assign aw_in = '{id: awid, addr: awaddr, user: awuser};
  assign w_in  = '{id: wid, data: wdata, user: wuser};
  assign b_in  = '{id: core_bid, resp: core_bresp, user: core_buser};

  axi_double_buffer #(.payload_t(aw_beat_t)) u_aw_db (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (awvalid),
    .in_ready  (awready),
    .in_data   (aw_in),
    .out_valid (aw_head_valid),
    .out_ready (pair_pop),
    .out_data  (aw_head),
    .status    (aw_status)
  );

  axi_double_buffer #(.payload_t(w_beat_t)) u_w_db (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (wvalid),
    .in_ready  (wready),
    .in_data   (w_in),
    .out_valid (w_head_valid),
    .out_ready (pair_pop),
    .out_data  (w_head),
    .status    (w_status)
  );

  axi_double_buffer #(.payload_t(b_beat_t)) u_b_db (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (core_bvalid),
    .in_ready  (core_bready),
    .in_data   (b_in),
    .out_valid (bvalid),
    .out_ready (bready),
    .out_data  (b_head),
    .status    (b_status)
  );

  assign bid   = b_head.id;
  assign bresp = b_head.resp;
  assign buser = b_head.user;

  // ------------------------------------------------------------------
  // AW/W pairing toward the core
  // ------------------------------------------------------------------
  assign pair_ready   = aw_head_valid && w_head_valid;
  assign core_awvalid = pair_ready && !aw_taken;
  assign core_wvalid  = pair_ready && !w_taken;

  assign core_awid   = aw_head.id;
  assign core_awaddr = aw_head.addr;
  assign core_awuser = aw_head.user;
  assign core_wid    = w_head.id;
  assign core_wdata  = w_head.data;
  assign core_wuser  = w_head.user;

  assign aw_hs = core_awvalid && core_awready;
  assign w_hs  = core_wvalid && core_wready;

  // both heads leave together once each half has been taken, now or earlier
  assign pair_pop = pair_ready && (aw_hs || aw_taken) && (w_hs || w_taken);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_taken <= 1'b0;
      w_taken  <= 1'b0;
    end else if (pair_pop) begin
      aw_taken <= 1'b0;
      w_taken  <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_taken <= 1'b1;
      end
      if (w_hs) begin
        w_taken <= 1'b1;
      end
    end
  end

  // a half taken while its partner is still pending is not offered again
  a_taken_masks_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (aw_hs && !pair_pop |=> !core_awvalid) and
    (w_hs && !pair_pop |=> !core_wvalid));

endmodule

/* hdl/axi_wr_regfile.sv */
//--------------------------------------------------------------------
// 16 x 32 bit register target, addresses above 63 answer SLVERR
// one AW and one W are held at a time, so a new pair waits for the B beat
//--------------------------------------------------------------------
`timescale 1ns/10ps

module axi_wr_regfile (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              core_awvalid,
  output logic                              core_awready,
  input  logic [axi_wr_pkg::id_width-1:0]   core_awid,
  input  logic [axi_wr_pkg::addr_width-1:0] core_awaddr,
  input  logic [axi_wr_pkg::user_width-1:0] core_awuser,
  input  logic                              core_wvalid,
  output logic                              core_wready,
  input  logic [axi_wr_pkg::id_width-1:0]   core_wid,
  input  logic [axi_wr_pkg::data_width-1:0] core_wdata,
  input  logic [axi_wr_pkg::user_width-1:0] core_wuser,
  output logic                              core_bvalid,
  input  logic                              core_bready,
  output logic [axi_wr_pkg::id_width-1:0]   core_bid,
  output logic [1:0]                        core_bresp,
  output logic [axi_wr_pkg::user_width-1:0] core_buser,
  input  logic [axi_wr_pkg::addr_width-1:0] rd_addr,
  output logic [axi_wr_pkg::data_width-1:0] rd_data
);

  import axi_wr_pkg::*;

  aw_beat_t aw_slot;
  w_beat_t  w_slot;
  b_beat_t  b_q;
  logic     aw_full;
  logic     w_full;
  logic     aw_take;
  logic     w_take;
  logic     b_free;
  logic     fire;
  logic     wr_in_range;
  logic     rd_in_range;

  logic [$clog2(reg_count)-1:0] wr_index;
  logic [$clog2(reg_count)-1:0] rd_index;
  logic [data_width-1:0]        regs [reg_count];

  assign core_awready = !aw_full;
  assign core_wready  = !w_full;
  assign aw_take      = core_awvalid && core_awready;
  assign w_take       = core_wvalid && core_wready;

  // a held B beat leaving this cycle makes room for the next one
  assign b_free = !core_bvalid || core_bready;
  assign fire   = aw_full && w_full && b_free;

  // word index from bits 5:2, anything above the bank is out of range
  assign wr_index    = aw_slot.addr[2 +: $clog2(reg_count)];
  assign wr_in_range = (aw_slot.addr[addr_width-1:2+$clog2(reg_count)] == '0);
  assign rd_index    = rd_addr[2 +: $clog2(reg_count)];
  assign rd_in_range = (rd_addr[addr_width-1:2+$clog2(reg_count)] == '0);

  assign rd_data = rd_in_range ? regs[rd_index] : '0;

  assign core_bid   = b_q.id;
  assign core_bresp = b_q.resp;
  assign core_buser = b_q.user;

  // ------------------------------------------------------------------
  // slot and response control
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aw_full     <= 1'b0;
      w_full      <= 1'b0;
      core_bvalid <= 1'b0;
    end else begin
      if (fire) begin
        aw_full <= 1'b0;
      end else if (aw_take) begin
        aw_full <= 1'b1;
      end
      if (fire) begin
        w_full <= 1'b0;
      end else if (w_take) begin
        w_full <= 1'b1;
      end
      if (fire) begin
        core_bvalid <= 1'b1;
      end else if (core_bready) begin
        core_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_take) begin
      aw_slot <= '{id: core_awid, addr: core_awaddr, user: core_awuser};
    end
    if (w_take) begin
      w_slot <= '{id: core_wid, data: core_wdata, user: core_wuser};
    end
    if (fire) begin
      b_q <= '{id: aw_slot.id, resp: wr_in_range ? resp_okay : resp_slverr,
               user: aw_slot.user};
    end
  end

  // the register bank itself
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (fire && wr_in_range) begin
      regs[wr_index] <= w_slot.data;
    end
  end

  // the master must pair each AW with the W of the same id
  a_id_match: assert property (@(posedge clk) disable iff (!rst_n)
    fire |-> (w_slot.id == aw_slot.id));

endmodule

/* hdl/axi_wr_subsys.sv */
//--------------------------------------------------------------------
// AXI write slave in front of the register bank, single-beat writes only
//--------------------------------------------------------------------
`timescale 1ns/10ps

module axi_wr_subsys (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     awvalid,
  output logic                                     awready,
  input  logic [axi_wr_pkg::id_width-1:0]          awid,
  input  logic [axi_wr_pkg::addr_width-1:0]        awaddr,
  input  logic [axi_wr_pkg::user_width-1:0]        awuser,
  input  logic                                     wvalid,
  output logic                                     wready,
  input  logic [axi_wr_pkg::id_width-1:0]          wid,
  input  logic [axi_wr_pkg::data_width-1:0]        wdata,
  input  logic [axi_wr_pkg::user_width-1:0]        wuser,
  output logic                                     bvalid,
  input  logic                                     bready,
  output logic [axi_wr_pkg::id_width-1:0]          bid,
  output logic [1:0]                               bresp,
  output logic [axi_wr_pkg::user_width-1:0]        buser,
  input  logic [axi_wr_pkg::addr_width-1:0]        rd_addr,
  output logic [axi_wr_pkg::data_width-1:0]        rd_data,
  output logic [3*axi_wr_pkg::db_status_width-1:0] db_status
);

  import axi_wr_pkg::*;

  // core side links between the slave and the register bank
  logic                  core_awvalid;
  logic                  core_awready;
  logic [id_width-1:0]   core_awid;
  logic [addr_width-1:0] core_awaddr;
  logic [user_width-1:0] core_awuser;
  logic                  core_wvalid;
  logic                  core_wready;
  logic [id_width-1:0]   core_wid;
  logic [data_width-1:0] core_wdata;
  logic [user_width-1:0] core_wuser;
  logic                  core_bvalid;
  logic                  core_bready;
  logic [id_width-1:0]   core_bid;
  logic [1:0]            core_bresp;
  logic [user_width-1:0] core_buser;

  axi_wr_slave u_slave (
    .clk          (clk),
    .rst_n        (rst_n),
    .awvalid      (awvalid),
    .awready      (awready),
    .awid         (awid),
    .awaddr       (awaddr),
    .awuser       (awuser),
    .wvalid       (wvalid),
    .wready       (wready),
    .wid          (wid),
    .wdata        (wdata),
    .wuser        (wuser),
    .bvalid       (bvalid),
    .bready       (bready),
    .bid          (bid),
    .bresp        (bresp),
    .buser        (buser),
    .core_awvalid (core_awvalid),
    .core_awready (core_awready),
    .core_awid    (core_awid),
    .core_awaddr  (core_awaddr),
    .core_awuser  (core_awuser),
    .core_wvalid  (core_wvalid),
    .core_wready  (core_wready),
    .core_wid     (core_wid),
    .core_wdata   (core_wdata),
    .core_wuser   (core_wuser),
    .core_bvalid  (core_bvalid),
    .core_bready  (core_bready),
    .core_bid     (core_bid),
    .core_bresp   (core_bresp),
    .core_buser   (core_buser),
    .db_status    (db_status)
  );

  axi_wr_regfile u_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_awvalid (core_awvalid),
    .core_awready (core_awready),
    .core_awid    (core_awid),
    .core_awaddr  (core_awaddr),
    .core_awuser  (core_awuser),
    .core_wvalid  (core_wvalid),
    .core_wready  (core_wready),
    .core_wid     (core_wid),
    .core_wdata   (core_wdata),
    .core_wuser   (core_wuser),
    .core_bvalid  (core_bvalid),
    .core_bready  (core_bready),
    .core_bid     (core_bid),
    .core_bresp   (core_bresp),
    .core_buser   (core_buser),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

endmodule

/* verification/tb_clk_gen.sv */
//--------------------------------------------------------------------
// 10 ns clock, rst_n held low until the second rising edge
//--------------------------------------------------------------------
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* verification/tb_axi_wr_subsys.sv */
//--------------------------------------------------------------------
// acts as the AXI master and B sink, AW and W of one entry share an id
// entries are sent one after another, the halves of one entry may be skewed
//--------------------------------------------------------------------
`timescale 1ns/10ps

module tb_axi_wr_subsys;

  import axi_wr_pkg::*;

  localparam int wait_limit = 200;

  // delay > 0 presents W that many cycles after AW, delay < 0 the reverse
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic [user_width-1:0] user;
    logic [1:0]            resp;
    logic signed [7:0]     delay;
  } entry_t;

  logic                           clk;
  logic                           rst_n;
  logic                           awvalid;
  logic                           awready;
  logic [id_width-1:0]            awid;
  logic [addr_width-1:0]          awaddr;
  logic [user_width-1:0]          awuser;
  logic                           wvalid;
  logic                           wready;
  logic [id_width-1:0]            wid;
  logic [data_width-1:0]          wdata;
  logic [user_width-1:0]          wuser;
  logic                           bvalid;
  logic                           bready;
  logic [id_width-1:0]            bid;
  logic [1:0]                     bresp;
  logic [user_width-1:0]          buser;
  logic [addr_width-1:0]          rd_addr;
  logic [data_width-1:0]          rd_data;
  logic [3*db_status_width-1:0]   db_status;

  entry_t                stim [20];
  b_beat_t               sb_q [$];
  b_beat_t               exp_b;
  logic [data_width-1:0] model [reg_count];
  logic [31:0]           lfsr = 32'hfdb7_8d3a;
  int                    bready_mode = 0;
  int                    errors = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  int                    test_start_errors = 0;
  int                    b_count = 0;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  axi_wr_subsys u_axi_wr_subsys (
    .clk       (clk),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .awid      (awid),
    .awaddr    (awaddr),
    .awuser    (awuser),
    .wvalid    (wvalid),
    .wready    (wready),
    .wid       (wid),
    .wdata     (wdata),
    .wuser     (wuser),
    .bvalid    (bvalid),
    .bready    (bready),
    .bid       (bid),
    .bresp     (bresp),
    .buser     (buser),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .db_status (db_status)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // ------------------------------------------------------------------
  // checking and reporting
  // ------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error: time %0t signal %s expected %h actual %h",
               $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("failure at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("%-22s passed", name);
    end else begin
      $display("%-22s failed with %0d errors", name, errors - test_start_errors);
      tests_failed++;
    end
    test_start_errors = errors;
  endtask

  // ------------------------------------------------------------------
  // master side drivers
  // ------------------------------------------------------------------
  task automatic drive_aw(input entry_t e);
    int waited;
    waited = 0;
    @(posedge clk);
    awvalid <= 1'b1;
    awid    <= e.id;
    awaddr  <= e.addr;
    awuser  <= e.user;
    @(negedge clk);
    while (!awready) begin
      waited++;
      if (waited > wait_limit) begin
        abort_run("awready stayed low while AW was offered");
      end
      @(negedge clk);
    end
    @(posedge clk);
    awvalid <= 1'b0;
  endtask

  task automatic drive_w(input entry_t e);
    int waited;
    waited = 0;
    @(posedge clk);
    wvalid <= 1'b1;
    wid    <= e.id;
    wdata  <= e.data;
    wuser  <= e.user;
    @(negedge clk);
    while (!wready) begin
      waited++;
      if (waited > wait_limit) begin
        abort_run("wready stayed low while W was offered");
      end
      @(negedge clk);
    end
    @(posedge clk);
    wvalid <= 1'b0;
  endtask

  // queues the expected B beat and register update, then sends both halves
  task automatic send_entry(input entry_t e);
    int d;
    int aw_lag;
    int w_lag;
    d      = int'(e.delay);
    aw_lag = (d < 0) ? -d : 0;
    w_lag  = (d > 0) ? d : 0;
    sb_q.push_back(b_beat_t'{id: e.id, resp: e.resp, user: e.user});
    if (e.resp == resp_okay) begin
      model[e.addr[5:2]] = e.data;
    end
    fork
      begin
        repeat (aw_lag) @(posedge clk);
        drive_aw(e);
      end
      begin
        repeat (w_lag) @(posedge clk);
        drive_w(e);
      end
    join
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (sb_q.size() != 0) begin
      waited++;
      if (waited > wait_limit) begin
        abort_run("expected B beats did not arrive");
      end
      @(negedge clk);
    end
    // the last beat seen at the falling edge transfers on the next rising edge
    @(posedge clk);
  endtask

  task automatic read_reg(input logic [addr_width-1:0] a,
                          output logic [data_width-1:0] d);
    @(posedge clk);
    rd_addr <= a;
    @(negedge clk);
    d = rd_data;
  endtask

  task automatic check_regs();
    logic [data_width-1:0] d;
    for (int i = 0; i < reg_count; i++) begin
      read_reg(addr_width'(i * 4), d);
      check_value($sformatf("rd_data[%0d]", i), model[i], d);
    end
  endtask

  // ------------------------------------------------------------------
  // B sink and scoreboard
  // ------------------------------------------------------------------
  always @(posedge clk) begin
    case (bready_mode)
      0: bready <= 1'b1;
      1: bready <= 1'b0;
      default: begin
        lfsr = lfsr_next(lfsr);
        bready <= lfsr[0];
      end
    endcase
  end

  // sampled at the falling edge, the transfer completes on the next rising one
  always @(negedge clk) begin
    if (rst_n && bvalid && bready) begin
      b_count++;
      if (sb_q.size() == 0) begin
        check_true(1'b0, $sformatf("unexpected B beat with id %h", bid));
      end else begin
        exp_b = sb_q.pop_front();
        check_value("bid", exp_b.id, bid);
        check_value("bresp", exp_b.resp, bresp);
        check_value("buser", exp_b.user, buser);
      end
    end
  end

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------
  initial begin
    logic [data_width-1:0] d;
    int waited;
    int lat;
    int sent;
    int start_count;

    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awuser  = '0;
    wvalid  = 1'b0;
    wid     = '0;
    wdata   = '0;
    wuser   = '0;
    bready  = 1'b1;
    rd_addr = '0;
    for (int i = 0; i < reg_count; i++) begin
      model[i] = '0;
    end

    // id, addr, data, user, expected response, W delay relative to AW
    stim[0]  = '{6'h01, 12'h000, 32'h1111_0001, 6'h05, resp_okay,    8'sd0};
    stim[1]  = '{6'h02, 12'h004, 32'h2222_0002, 6'h0a, resp_okay,    8'sd0};
    stim[2]  = '{6'h03, 12'h008, 32'h3333_0003, 6'h11, resp_okay,    8'sd0};
    stim[3]  = '{6'h04, 12'h03c, 32'h4444_0004, 6'h3f, resp_okay,    8'sd0};
    stim[4]  = '{6'h05, 12'h010, 32'h5555_0005, 6'h01, resp_okay,    8'sd3};
    stim[5]  = '{6'h06, 12'h014, 32'h6666_0006, 6'h02, resp_okay,   -8'sd4};
    stim[6]  = '{6'h07, 12'h018, 32'h7777_0007, 6'h03, resp_okay,    8'sd1};
    stim[7]  = '{6'h08, 12'h010, 32'h8888_0008, 6'h04, resp_okay,   -8'sd2};
    stim[8]  = '{6'h09, 12'h040, 32'hdead_0009, 6'h15, resp_slverr,  8'sd0};
    stim[9]  = '{6'h0a, 12'hffc, 32'hdead_000a, 6'h2a, resp_slverr,  8'sd2};
    stim[10] = '{6'h0b, 12'h020, 32'ha5a5_000b, 6'h06, resp_okay,    8'sd0};
    stim[11] = '{6'h0c, 12'h024, 32'ha5a5_000c, 6'h07, resp_okay,    8'sd0};
    stim[12] = '{6'h0d, 12'h028, 32'ha5a5_000d, 6'h08, resp_okay,    8'sd0};
    stim[13] = '{6'h0e, 12'h02c, 32'ha5a5_000e, 6'h09, resp_okay,    8'sd0};
    stim[14] = '{6'h0f, 12'h030, 32'ha5a5_000f, 6'h0b, resp_okay,    8'sd0};
    stim[15] = '{6'h10, 12'h034, 32'ha5a5_0010, 6'h0c, resp_okay,    8'sd0};
    stim[16] = '{6'h11, 12'h038, 32'h5a5a_0011, 6'h0d, resp_okay,   -8'sd1};
    stim[17] = '{6'h12, 12'h100, 32'h5a5a_0012, 6'h0e, resp_slverr,  8'sd0};
    stim[18] = '{6'h13, 12'h000, 32'h5a5a_0013, 6'h1f, resp_okay,    8'sd1};
    stim[19] = '{6'h14, 12'h03c, 32'h5a5a_0014, 6'h20, resp_okay,    8'sd0};

    waited = 0;
    while (rst_n !== 1'b1) begin
      waited++;
      if (waited > 10) begin
        abort_run("reset was never released");
      end
      @(posedge clk);
    end

    @(negedge clk);
    check_value("awready", 1, awready);
    check_value("wready", 1, wready);
    check_value("bvalid", 0, bvalid);
    check_value("db_status", 0, db_status);
    check_regs();
    end_test("reset_state");

    // one write at a time, so the response latency is the unstalled one
    for (int i = 0; i < 4; i++) begin
      send_entry(stim[i]);
      lat = 0;
      @(negedge clk);
      while (!bvalid) begin
        lat++;
        if (lat > wait_limit) begin
          abort_run("bvalid never rose after a write");
        end
        @(negedge clk);
      end
      check_value("bvalid latency", 3, lat);
      wait_drain();
    end
    check_regs();
    end_test("simple_writes");

    start_count = b_count;
    for (int i = 4; i < 8; i++) begin
      send_entry(stim[i]);
    end
    wait_drain();
    check_value("B beat count", 4, b_count - start_count);
    check_regs();
    end_test("separated_halves");

    start_count = b_count;
    send_entry(stim[8]);
    send_entry(stim[9]);
    wait_drain();
    check_value("B beat count", 2, b_count - start_count);
    check_regs();
    read_reg(12'h040, d);
    check_value("rd_data", 0, d);
    read_reg(12'hffc, d);
    check_value("rd_data", 0, d);
    end_test("address_out_of_range");

    // hold bready low and keep writing until the AW buffer is full
    bready_mode = 1;
    repeat (2) @(posedge clk);
    start_count = b_count;
    sent = 0;
    for (int i = 10; i < 20; i++) begin
      @(negedge clk);
      if (!awready) begin
        break;
      end
      send_entry(stim[i]);
      sent++;
    end
    @(negedge clk);
    check_true(!awready, "awready did not drop while bready was held low");
    check_true(!wready, "wready did not drop while bready was held low");
    check_value("db_status aw count", 2, db_status[1:0]);
    check_value("db_status w count", 2, db_status[3:2]);
    check_value("db_status b count", 2, db_status[5:4]);
    bready_mode = 0;
    wait_drain();
    check_value("B beat count", sent, b_count - start_count);
    @(negedge clk);
    check_value("awready", 1, awready);
    check_value("db_status", 0, db_status);
    check_regs();
    end_test("b_backpressure");

    bready_mode = 2;
    start_count = b_count;
    for (int i = 0; i < 20; i++) begin
      send_entry(stim[i]);
    end
    wait_drain();
    bready_mode = 0;
    check_value("B beat count", 20, b_count - start_count);
    check_regs();
    end_test("random_stalls");

    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
hdl/axi_wr_pkg.sv
hdl/axi_double_buffer.sv
hdl/axi_wr_slave.sv
hdl/axi_wr_regfile.sv
hdl/axi_wr_subsys.sv
verification/tb_clk_gen.sv
verification/tb_axi_wr_subsys.sv

/* Bender.yml */
package:
  name: axi_wr_subsys

sources:
  # design sources in compile order
  - files:
      - hdl/axi_wr_pkg.sv
      - hdl/axi_double_buffer.sv
      - hdl/axi_wr_slave.sv
      - hdl/axi_wr_regfile.sv
      - hdl/axi_wr_subsys.sv

  # testbench, top module tb_axi_wr_subsys
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_axi_wr_subsys.sv
